// File: readout_top.f
logic/readout_pkg.sv
logic/sample_fifo.sv
logic/trigger_tagger.sv
logic/packet_framer.sv
logic/link_arbiter.sv
logic/readout_top.sv
verif/readout_assert.sv
verif/readout_tb.sv

// File: verif/readout_tb.sv
`timescale 1ns/10ps

module readout_tb;
	import readout_pkg::*;

	localparam int N_RAND      = 16;
	localparam int PKT_PLANNED = NUM_CHAN * (1 + N_RAND + 3 + 1);
	localparam int WD_CYCLES   = 400 * PKT_PLANNED + 2000;

	logic        RCLK;
	logic        rst_resync;
	logic        l1a;
	logic        l1a_match;
	sample_t     samp_data0;
	sample_t     samp_data1;
	logic        samp_wr0;
	logic        samp_wr1;
	logic        credit_ret;
	link_word_t  txd;
	logic        txd_vld;
	logic        samp_ovf0;
	logic        samp_ovf1;
	logic        trig_ovf;

	integer      seed = 32'ha9162f98;
	logic [31:0] rnd_crd;
	int          errors;
	int          cycle;
	int          word_cnt;
	int          stall_words;
	int          pkt_done;
	int          pkt_plan;
	int          pkt_idx;
	logic        stall;
	int          due_q[$];                  // cycles when credits go back
	sample_t     samp_q[NUM_CHAN][$];
	trig_rec_t   rec_q[NUM_CHAN][$];
	link_word_t  pkt_buf[PKT_WORDS];
	logic [11:0] trig_model;
	logic [11:0] match_model;

	readout_top i_dut (.*);

	initial begin
		RCLK = 1'b0;
		forever #20 RCLK = ~RCLK;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge RCLK);
		$display("timeout after %0d cycles, packets still missing", WD_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act == exp) else begin
			errors++;
			$display("MISMATCH %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic compare_packet();
		int          ch;
		trig_rec_t   rec;
		sample_t     s;
		logic [14:0] crc;
		ch = pkt_done % NUM_CHAN;               // channels take turns
		check_val("txd trailer", {TRAILER_BASE, 4'(ch), 4'hF}, pkt_buf[PKT_WORDS-1]);
		if (rec_q[ch].size() == 0 || samp_q[ch].size() < SAMP_COUNT) begin
			errors++;
			$display("packet on channel %0d has no trigger or samples behind it", ch);
		end else begin
			rec = rec_q[ch].pop_front();
			check_val("txd trigger high", {4'h0, rec.match_cnt}, pkt_buf[0]);
			check_val("txd trigger low", {4'h0, rec.trig_lo}, pkt_buf[1]);
			crc = '0;
			for (int i = 0; i < SAMP_COUNT; i++) begin
				s = samp_q[ch].pop_front();
				check_val("txd sample", {4'h4, s}, pkt_buf[2+i]);
				crc = crc15_d13({1'b0, s}, crc);
			end
			check_val("txd crc", {1'b0, crc}, pkt_buf[PKT_WORDS-2]);
		end
		pkt_done++;
	endtask

	// link monitor and credit bookkeeping
	always @(negedge RCLK) begin
		if (!rst_resync && txd_vld) begin
			rnd_crd = $random(seed);
			word_cnt++;
			if (stall)
				stall_words++;
			due_q.push_back(cycle + 1 + int'(rnd_crd[7:0] % 6));
			pkt_buf[pkt_idx] = txd;
			if (pkt_idx == PKT_WORDS - 1) begin
				compare_packet();
				pkt_idx = 0;
			end else begin
				pkt_idx++;
			end
		end
	end

	// credit responder returns at most one credit per cycle
	always @(posedge RCLK) begin
		cycle++;
		if (!stall && due_q.size() != 0 && due_q[0] <= cycle) begin
			credit_ret <= 1'b1;
			void'(due_q.pop_front());
		end else begin
			credit_ret <= 1'b0;
		end
	end

	task automatic load_samples();
		logic [31:0] rnd;
		sample_t     s0;
		sample_t     s1;
		for (int i = 0; i < SAMP_COUNT; i++) begin
			rnd = $random(seed);
			s0  = rnd[11:0];
			s1  = rnd[27:16];
			@(posedge RCLK);
			samp_wr0   <= 1'b1;
			samp_wr1   <= 1'b1;
			samp_data0 <= s0;
			samp_data1 <= s1;
			samp_q[0].push_back(s0);
			samp_q[1].push_back(s1);
		end
		@(posedge RCLK);
		samp_wr0 <= 1'b0;
		samp_wr1 <= 1'b0;
	endtask

	task automatic fire_trigger(input logic matched);
		@(posedge RCLK);
		l1a       <= 1'b1;
		l1a_match <= matched;
		if (matched) begin
			for (int c = 0; c < NUM_CHAN; c++)
				rec_q[c].push_back(trig_rec_t'({match_model, trig_model}));
			match_model++;
			pkt_plan += NUM_CHAN;
		end
		trig_model++;
		@(posedge RCLK);
		l1a       <= 1'b0;
		l1a_match <= 1'b0;
	endtask

	task automatic wait_packets(input int n);
		while (pkt_done < n)
			@(posedge RCLK);
	endtask

	task automatic drain_credits();
		while (due_q.size() != 0)
			@(negedge RCLK);
		repeat (4) @(posedge RCLK);
	endtask

	task automatic overfill_chan0();
		for (int i = 0; i < SAMP_FIFO_DEPTH + 2; i++) begin
			@(posedge RCLK);
			samp_wr0   <= 1'b1;
			samp_data0 <= sample_t'(i);
		end
		@(posedge RCLK);
		samp_wr0 <= 1'b0;
	endtask

	initial begin
		rst_resync  = 1'b1;
		l1a         = 1'b0;
		l1a_match   = 1'b0;
		samp_data0  = '0;
		samp_data1  = '0;
		samp_wr0    = 1'b0;
		samp_wr1    = 1'b0;
		credit_ret  = 1'b0;
		stall       = 1'b0;
		trig_model  = '0;
		match_model = '0;
		repeat (2) @(posedge RCLK);
		rst_resync <= 1'b0;
		repeat (10) @(posedge RCLK);
		check_val("txd_vld word count", 0, word_cnt);   // idle link
		repeat (3) fire_trigger(1'b0);                  // counted but no packet
		load_samples();
		fire_trigger(1'b1);
		wait_packets(pkt_plan);
		check_val("txd_vld word count", NUM_CHAN * PKT_WORDS, word_cnt);
		for (int i = 0; i < N_RAND; i++) begin
			load_samples();
			fire_trigger(1'b1);
			if (i % 4 == 1)
				fire_trigger(1'b0);
			wait_packets(pkt_plan - 2 * NUM_CHAN);     // two triggers ahead at most
		end
		wait_packets(pkt_plan);
		repeat (3) load_samples();                      // both channels loaded at once
		repeat (3) fire_trigger(1'b1);
		wait_packets(pkt_plan);
		drain_credits();
		stall <= 1'b1;                                  // receiver withholds credits
		stall_words = 0;
		load_samples();
		fire_trigger(1'b1);
		repeat (40) @(posedge RCLK);
		check_val("txd_vld words while stalled", LINK_CREDITS, stall_words);
		stall <= 1'b0;
		wait_packets(pkt_plan);
		drain_credits();
		@(negedge RCLK);
		check_val("samp_ovf0", 0, samp_ovf0);           // nothing overflowed yet
		overfill_chan0();
		@(negedge RCLK);
		check_val("samp_ovf0", 1, samp_ovf0);
		repeat (20) @(negedge RCLK);
		check_val("samp_ovf0", 1, samp_ovf0);
		check_val("samp_ovf1", 0, samp_ovf1);
		check_val("trig_ovf", 0, trig_ovf);
		@(posedge RCLK);
		rst_resync <= 1'b1;
		repeat (2) @(posedge RCLK);
		rst_resync <= 1'b0;
		@(negedge RCLK);
		check_val("samp_ovf0 after reset", 0, samp_ovf0);
		check_val("packet count", pkt_plan, pkt_done);
		$display("summary: %0d mismatch errors, %0d assertion failures",
			errors, i_dut.i_arbiter.i_assert.fail_cnt);
		if (errors == 0 && i_dut.i_arbiter.i_assert.fail_cnt == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: verif/readout_assert.sv
`timescale 1ns/10ps

module readout_assert
	import readout_pkg::*;
(
	input logic              RCLK,
	input logic              rst_resync,
	input logic              take0,
	input logic              take1,
	input logic              credit_ret,
	input logic              txd_vld,
	input link_word_t        txd,
	input logic [CRED_W-1:0] credits,
	input logic              busy
);

	int                fail_cnt = 0;   // failures seen so far
	int                link_cred;      // credits rebuilt from link traffic
	int                free_cred;
	logic [WCNT_W-1:0] pos0;           // words taken from the current packet
	logic [WCNT_W-1:0] pos1;

	// a word on txd spends the credit its take used one cycle earlier
	assign free_cred = link_cred - int'(txd_vld);

	always_ff @(posedge RCLK or posedge rst_resync) begin
		if (rst_resync) begin
			link_cred <= LINK_CREDITS;
			pos0      <= '0;
			pos1      <= '0;
		end else begin
			link_cred <= link_cred - int'(txd_vld) + int'(credit_ret);
			if (take0)
				pos0 <= (pos0 == W_TRAILER) ? '0 : pos0 + 1'b1;
			if (take1)
				pos1 <= (pos1 == W_TRAILER) ? '0 : pos1 + 1'b1;
		end
	end

	credit_gate: assert property (@(posedge RCLK) disable iff (rst_resync)
		txd_vld |-> $past(free_cred) > 0)
	else begin
		fail_cnt++;
		$error("link word sent with no credit available");
	end

	credit_max: assert property (@(posedge RCLK) disable iff (rst_resync)
		credits <= CRED_W'(LINK_CREDITS))
	else begin
		fail_cnt++;
		$error("credit count above the link limit");
	end

	// a take never lands inside the other channel's packet
	no_interleave: assert property (@(posedge RCLK) disable iff (rst_resync)
		!(take0 && take1) && !(take0 && pos1 != '0) && !(take1 && pos0 != '0))
	else begin
		fail_cnt++;
		$error("packets from two channels interleaved");
	end

	trailer_end: assert property (@(posedge RCLK) disable iff (rst_resync)
		$fell(busy) |-> txd_vld && txd[15:8] == TRAILER_BASE && txd[3:0] == 4'hF)
	else begin
		fail_cnt++;
		$error("link grant released without a trailer word");
	end

endmodule

bind link_arbiter readout_assert i_assert (.*);

// File: logic/readout_top.sv
`timescale 1ns/10ps

module readout_top
	import readout_pkg::*;
(
	input  logic       RCLK,
	input  logic       rst_resync,
	input  logic       l1a,
	input  logic       l1a_match,
	input  sample_t    samp_data0,
	input  sample_t    samp_data1,
	input  logic       samp_wr0,
	input  logic       samp_wr1,
	input  logic       credit_ret,
	output link_word_t txd,
	output logic       txd_vld,
	output logic       samp_ovf0,
	output logic       samp_ovf1,
	output logic       trig_ovf
);

	logic                  rec_push;
	trig_rec_t             rec_in;
	trig_rec_t             rec0, rec1;
	logic                  rec_empty0, rec_empty1;
	logic                  rec_rd0, rec_rd1;
	logic                  trig_ovf0, trig_ovf1;
	sample_t               samp0, samp1;
	logic [SAMP_LVL_W-1:0] samp_level0, samp_level1;
	logic                  samp_rd0, samp_rd1;
	logic                  req0, req1;
	link_word_t            word0, word1;
	logic                  last0, last1;
	logic                  take0, take1;

	assign trig_ovf = trig_ovf0 | trig_ovf1;

	trigger_tagger i_tagger (
		.RCLK(RCLK), .rst_resync(rst_resync), .l1a(l1a), .l1a_match(l1a_match),
		.rec_push(rec_push), .rec(rec_in)
	);

	sample_fifo #(.payload_t(sample_t), .DEPTH(SAMP_FIFO_DEPTH)) i_samp_fifo0 (
		.RCLK(RCLK), .rst_resync(rst_resync), .wr(samp_wr0), .din(samp_data0),
		.rd(samp_rd0), .dout(samp0), .empty(), .level(samp_level0), .ovf(samp_ovf0)
	);

	sample_fifo #(.payload_t(sample_t), .DEPTH(SAMP_FIFO_DEPTH)) i_samp_fifo1 (
		.RCLK(RCLK), .rst_resync(rst_resync), .wr(samp_wr1), .din(samp_data1),
		.rd(samp_rd1), .dout(samp1), .empty(), .level(samp_level1), .ovf(samp_ovf1)
	);

	sample_fifo #(.payload_t(trig_rec_t), .DEPTH(TRIG_FIFO_DEPTH)) i_trig_fifo0 (
		.RCLK(RCLK), .rst_resync(rst_resync), .wr(rec_push), .din(rec_in),
		.rd(rec_rd0), .dout(rec0), .empty(rec_empty0), .level(), .ovf(trig_ovf0)
	);

	sample_fifo #(.payload_t(trig_rec_t), .DEPTH(TRIG_FIFO_DEPTH)) i_trig_fifo1 (
		.RCLK(RCLK), .rst_resync(rst_resync), .wr(rec_push), .din(rec_in),
		.rd(rec_rd1), .dout(rec1), .empty(rec_empty1), .level(), .ovf(trig_ovf1)
	);

	packet_framer #(.CHAN_ID(4'd0)) i_framer0 (
		.RCLK(RCLK), .rst_resync(rst_resync), .rec(rec0), .rec_empty(rec_empty0),
		.samp(samp0), .samp_level(samp_level0), .take(take0), .rec_rd(rec_rd0),
		.samp_rd(samp_rd0), .req(req0), .word(word0), .last(last0)
	);

	packet_framer #(.CHAN_ID(4'd1)) i_framer1 (
		.RCLK(RCLK), .rst_resync(rst_resync), .rec(rec1), .rec_empty(rec_empty1),
		.samp(samp1), .samp_level(samp_level1), .take(take1), .rec_rd(rec_rd1),
		.samp_rd(samp_rd1), .req(req1), .word(word1), .last(last1)
	);

	link_arbiter i_arbiter (
		.RCLK(RCLK), .rst_resync(rst_resync), .req0(req0), .req1(req1),
		.word0(word0), .word1(word1), .last0(last0), .last1(last1),
		.credit_ret(credit_ret), .take0(take0), .take1(take1),
		.txd(txd), .txd_vld(txd_vld)
	);

endmodule

// File: logic/link_arbiter.sv
`timescale 1ns/10ps

module link_arbiter
	import readout_pkg::*;
(
	input  logic       RCLK,
	input  logic       rst_resync,
	input  logic       req0,
	input  logic       req1,
	input  link_word_t word0,
	input  link_word_t word1,
	input  logic       last0,
	input  logic       last1,
	input  logic       credit_ret,
	output logic       take0,
	output logic       take1,
	output link_word_t txd,
	output logic       txd_vld
);

	logic [NUM_CHAN-1:0]   req_v;
	logic [NUM_CHAN-1:0]   last_v;
	link_word_t            word_v [NUM_CHAN];
	logic [NUM_CHAN-1:0]   take_v;

	logic                  busy;        // a packet owns the link
	logic [CHAN_SEL_W-1:0] owner;
	logic [CHAN_SEL_W-1:0] rr_last;     // channel served last
	logic [CHAN_SEL_W-1:0] pick;
	logic                  pick_vld;
	logic [CHAN_SEL_W-1:0] gnt_sel;
	logic                  take_any;
	logic [CRED_W-1:0]     credits;

	assign req_v     = {req1, req0};
	assign last_v    = {last1, last0};
	assign word_v[0] = word0;
	assign word_v[1] = word1;

	// round robin, nearest channel after rr_last wins
	always_comb begin
		int idx;
		pick     = rr_last;
		pick_vld = 1'b0;
		for (int i = NUM_CHAN; i >= 1; i--) begin
			idx = (int'(rr_last) + i) % NUM_CHAN;
			if (req_v[idx]) begin
				pick     = CHAN_SEL_W'(idx);
				pick_vld = 1'b1;
			end
		end
	end

	assign gnt_sel  = busy ? owner : pick;
	assign take_any = (busy || pick_vld) && req_v[gnt_sel] && (credits != '0);

	always_comb begin
		take_v          = '0;
		take_v[gnt_sel] = take_any;
	end

	assign take0 = take_v[0];
	assign take1 = take_v[1];

	always_ff @(posedge RCLK or posedge rst_resync) begin
		if (rst_resync) begin
			busy    <= 1'b0;
			owner   <= '0;
			rr_last <= CHAN_SEL_W'(NUM_CHAN - 1);   // channel 0 goes first
			credits <= CRED_W'(LINK_CREDITS);
			txd_vld <= 1'b0;
		end else begin
			if (take_any) begin
				busy  <= !last_v[gnt_sel];          // lock until trailer
				owner <= gnt_sel;
				if (last_v[gnt_sel])
					rr_last <= gnt_sel;
			end
			case ({take_any, credit_ret})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
			txd_vld <= take_any;
		end
	end

	always_ff @(posedge RCLK) begin
		if (take_any)
			txd <= word_v[gnt_sel];
	end

endmodule

// File: logic/packet_framer.sv
`timescale 1ns/10ps

module packet_framer
	import readout_pkg::*;
#(
	parameter logic [3:0] CHAN_ID = 4'd0
) (
	input  logic                  RCLK,
	input  logic                  rst_resync,
	input  trig_rec_t             rec,
	input  logic                  rec_empty,
	input  sample_t               samp,
	input  logic [SAMP_LVL_W-1:0] samp_level,
	input  logic                  take,
	output logic                  rec_rd,
	output logic                  samp_rd,
	output logic                  req,
	output link_word_t            word,
	output logic                  last
);

	typedef enum logic {
		ST_IDLE,
		ST_SEND
	} state_t;

	state_t             state;
	logic [WCNT_W-1:0]  wcnt;        // index of the word on offer
	logic [CRC_W-1:0]   crc;
	logic               pkt_ready;
	logic               samp_phase;

	// a trigger waits and its samples are all buffered
	assign pkt_ready  = !rec_empty && (samp_level >= SAMP_LVL_W'(SAMP_COUNT));
	assign samp_phase = (wcnt >= W_SAMP_FIRST) && (wcnt <= W_SAMP_LAST);

	assign req     = (state == ST_SEND);
	assign last    = (wcnt == W_TRAILER);
	assign rec_rd  = take && (wcnt == W_TRIG_LO);   // record done after low word
	assign samp_rd = take && samp_phase;

	always_comb begin
		case (wcnt)
			W_TRIG_HI: word = {4'h0, rec.match_cnt};
			W_TRIG_LO: word = {4'h0, rec.trig_lo};
			W_CRC:     word = {1'b0, crc};
			W_TRAILER: word = {TRAILER_BASE, CHAN_ID, 4'hF};
			default:   word = {4'h4, samp};            // sample words
		endcase
	end

	always_ff @(posedge RCLK or posedge rst_resync) begin
		if (rst_resync) begin
			state <= ST_IDLE;
			wcnt  <= '0;
			crc   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (pkt_ready) begin
						state <= ST_SEND;
						wcnt  <= '0;
						crc   <= '0;                   // fresh CRC per packet
					end
				end
				ST_SEND: begin
					// without a take the word and CRC hold
					if (take) begin
						if (last) begin
							state <= ST_IDLE;
							wcnt  <= '0;
						end else begin
							wcnt <= wcnt + 1'b1;
						end
						if (samp_phase)
							crc <= crc15_d13({1'b0, samp}, crc);
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// File: logic/trigger_tagger.sv
`timescale 1ns/10ps

module trigger_tagger
	import readout_pkg::*;
(
	input  logic      RCLK,
	input  logic      rst_resync,
	input  logic      l1a,
	input  logic      l1a_match,
	output logic      rec_push,
	output trig_rec_t rec
);

	logic [TRIG_CNT_W-1:0] trig_cnt;
	logic [11:0]           match_cnt;

	always_ff @(posedge RCLK or posedge rst_resync) begin
		if (rst_resync) begin
			trig_cnt  <= '0;
			match_cnt <= '0;
			rec_push  <= 1'b0;
		end else begin
			if (l1a)
				trig_cnt <= trig_cnt + 1'b1;
			if (l1a_match)
				match_cnt <= match_cnt + 1'b1;
			rec_push <= l1a_match;          // one cycle after the match
		end
	end

	// record carries the counts from before this trigger
	always_ff @(posedge RCLK) begin
		if (l1a_match) begin
			rec.match_cnt <= match_cnt;
			rec.trig_lo   <= trig_cnt[11:0];
		end
	end

endmodule

// File: logic/sample_fifo.sv
`timescale 1ns/10ps

module sample_fifo #(
	parameter type payload_t = logic [11:0],
	parameter int  DEPTH     = 32
) (
	input  logic                     RCLK,
	input  logic                     rst_resync,
	input  logic                     wr,
	input  payload_t                 din,
	input  logic                     rd,
	output payload_t                 dout,
	output logic                     empty,
	output logic [$clog2(DEPTH):0]   level,
	output logic                     ovf
);

	localparam int PTR_W = $clog2(DEPTH);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full  = (count == (PTR_W+1)'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;   // read of an empty FIFO is ignored

	assign dout  = mem[rd_ptr];    // head shows through
	assign level = count;

	always_ff @(posedge RCLK) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge RCLK or posedge rst_resync) begin
		if (rst_resync) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;       // both or neither
			endcase
		end
	end

	// overflow stays until reset
	always_ff @(posedge RCLK or posedge rst_resync) begin
		if (rst_resync)
			ovf <= 1'b0;
		else if (wr && full)
			ovf <= 1'b1;
	end

endmodule

// File: logic/readout_pkg.sv
package readout_pkg;

	localparam int SAMP_W          = 12;
	localparam int SAMP_COUNT      = 8;
	localparam int NUM_CHAN        = 2;
	localparam int LINK_CREDITS    = 4;
	localparam int SAMP_FIFO_DEPTH = 32;
	localparam int TRIG_FIFO_DEPTH = 8;
	localparam int PKT_WORDS       = 2 + SAMP_COUNT + 2;
	localparam logic [7:0] TRAILER_BASE = 8'h7F;

	localparam int CRC_W       = 15;
	localparam int TRIG_CNT_W  = 24;
	localparam int SAMP_LVL_W  = $clog2(SAMP_FIFO_DEPTH) + 1;
	localparam int WCNT_W      = $clog2(PKT_WORDS);
	localparam int CRED_W      = $clog2(LINK_CREDITS + 1);
	localparam int CHAN_SEL_W  = (NUM_CHAN > 1) ? $clog2(NUM_CHAN) : 1;

	// word positions inside a packet
	localparam logic [WCNT_W-1:0] W_TRIG_HI    = WCNT_W'(0);
	localparam logic [WCNT_W-1:0] W_TRIG_LO    = WCNT_W'(1);
	localparam logic [WCNT_W-1:0] W_SAMP_FIRST = WCNT_W'(2);
	localparam logic [WCNT_W-1:0] W_SAMP_LAST  = WCNT_W'(2 + SAMP_COUNT - 1);
	localparam logic [WCNT_W-1:0] W_CRC        = WCNT_W'(2 + SAMP_COUNT);
	localparam logic [WCNT_W-1:0] W_TRAILER    = WCNT_W'(PKT_WORDS - 1);

	typedef logic [SAMP_W-1:0] sample_t;

	typedef struct packed {
		logic [11:0] match_cnt;   // matched triggers before this one
		logic [11:0] trig_lo;     // low bits of the trigger count
	} trig_rec_t;

	typedef logic [15:0] link_word_t;

	// next CRC-15 state after 13 data bits
	function automatic logic [CRC_W-1:0] crc15_d13(input logic [12:0] d,
			input logic [CRC_W-1:0] c);
		logic [CRC_W-1:0] n;
		n[0]  = d[0]  ^ c[2];
		n[1]  = d[0]  ^ d[1]  ^ c[2]  ^ c[3];
		n[2]  = d[1]  ^ d[2]  ^ c[3]  ^ c[4];
		n[3]  = d[2]  ^ d[3]  ^ c[4]  ^ c[5];
		n[4]  = d[3]  ^ d[4]  ^ c[5]  ^ c[6];
		n[5]  = d[4]  ^ d[5]  ^ c[6]  ^ c[7];
		n[6]  = d[5]  ^ d[6]  ^ c[7]  ^ c[8];
		n[7]  = d[6]  ^ d[7]  ^ c[8]  ^ c[9];
		n[8]  = d[7]  ^ d[8]  ^ c[9]  ^ c[10];
		n[9]  = d[8]  ^ d[9]  ^ c[10] ^ c[11];
		n[10] = d[9]  ^ d[10] ^ c[11] ^ c[12];
		n[11] = d[10] ^ d[11] ^ c[12] ^ c[13];
		n[12] = d[11] ^ d[12] ^ c[13] ^ c[14];
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage
